// File: verilog/ppu_pkg.sv
// Register map, frame timing constants and shared bus structs
// for the background PPU design, imported inside each module body
`default_nettype none

package ppu_pkg;

  // CPU register addresses
  localparam logic [2:0] REG_CTRL   = 3'd0;
  localparam logic [2:0] REG_MASK   = 3'd1;
  localparam logic [2:0] REG_STATUS = 3'd2;
  localparam logic [2:0] REG_SCROLL = 3'd5;
  localparam logic [2:0] REG_ADDR   = 3'd6;
  localparam logic [2:0] REG_DATA   = 3'd7;

  // Frame timing
  localparam logic [5:0] LAST_CYCLE_GROUP  = 6'd42;   // Cycles 336..343
  localparam logic [8:0] VBLANK_START_LINE = 9'd240;
  localparam logic [8:0] VBLANK_END_LINE   = 9'd260;
  localparam logic [8:0] PRE_RENDER_LINE   = 9'h1FF;  // Line -1
  localparam logic [8:0] COARSE_X_END      = 9'd256;
  localparam logic [8:0] PREFETCH_START    = 9'd320;
  localparam logic [8:0] PREFETCH_END      = 9'd336;
  localparam logic [8:0] V_INCR_CYCLE      = 9'd251;
  localparam logic [8:0] H_COPY_CYCLE      = 9'd256;
  localparam logic [8:0] V_COPY_CYCLE      = 9'd304;

  // Address space
  localparam logic [5:0] PALETTE_PAGE  = 6'h3F;      // 0x3F00..0x3FFF
  localparam logic [4:0] COARSE_Y_WRAP = 5'd29;      // Last row of a name table

  typedef struct packed {
    logic [2:0] ain;
    logic [7:0] din;
    logic       read;
    logic       write;
  } cpu_bus_t;

  typedef struct packed {
    logic [13:0] addr;
    logic        rd;
    logic        wr;
    logic [7:0]  wdata;
  } vram_req_t;

  typedef struct packed {
    logic [8:0] scanline;
    logic [8:0] cycle;
  } scan_pos_t;

  typedef struct packed {
    logic end_of_line;
    logic at_last_cycle_group;
    logic entering_vblank;
    logic exiting_vblank;
    logic is_pre_render;
    logic in_vblank;
  } scan_events_t;

  // Control and mask flags seen outside the control block
  typedef struct packed {
    logic bg_patt;
    logic vbl_enable;
    logic grayscale;
    logic playfield_clip;
    logic enable_playfield;
  } ppu_ctrl_t;

endpackage

`default_nettype wire

// File: verilog/scan_timer.sv
// Cycle and scanline counters for a 341 x 262 frame
// Flags vblank edges and the pre-render line for the rest of the PPU
`default_nettype none

module scan_timer (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  ce,
  input  logic                  is_rendering,
  output ppu_pkg::scan_pos_t    pos,
  output ppu_pkg::scan_events_t events
);
  import ppu_pkg::*;

  logic [8:0] cycle;
  logic [8:0] scanline;
  logic       in_vblank;
  logic       is_pre_render;
  logic       second_frame;    // Frame parity, toggles each vblank exit
  logic       at_last_group;
  logic       end_of_line;
  logic       short_line;

  assign at_last_group = (cycle[8:3] == LAST_CYCLE_GROUP);
  // Odd frames drop cycle 340 of the pre-render line
  assign short_line  = is_pre_render && second_frame && is_rendering;
  assign end_of_line = at_last_group && (cycle[3:0] == (short_line ? 4'd3 : 4'd4));

  assign events.end_of_line         = end_of_line;
  assign events.at_last_cycle_group = at_last_group;
  assign events.entering_vblank     = end_of_line && (scanline == VBLANK_START_LINE);
  assign events.exiting_vblank      = end_of_line && (scanline == VBLANK_END_LINE);
  assign events.is_pre_render       = is_pre_render;
  assign events.in_vblank           = in_vblank;

  assign pos.cycle    = cycle;
  assign pos.scanline = scanline;

  always_ff @(posedge clk) begin
    if (reset) begin
      cycle         <= 9'd0;
      scanline      <= 9'd0;
      in_vblank     <= 1'b1;
      is_pre_render <= 1'b0;
      second_frame  <= 1'b0;
    end else if (ce) begin
      cycle <= end_of_line ? 9'd0 : cycle + 9'd1;
      if (events.entering_vblank) in_vblank <= 1'b1;
      else if (events.exiting_vblank) in_vblank <= 1'b0;
      if (end_of_line) begin
        scanline      <= events.exiting_vblank ? PRE_RENDER_LINE : scanline + 9'd1;
        is_pre_render <= events.exiting_vblank;
        if (events.exiting_vblank) second_frame <= !second_frame;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/loopy_scroll.sv
// Scroll address registers v and t, fine X and the shared write latch
// Updated by CPU register writes or by the render-time increments and copies
`default_nettype none

module loopy_scroll (
  input  logic               clk,
  input  logic               reset,
  input  logic               ce,
  input  logic               is_rendering,
  input  ppu_pkg::cpu_bus_t  cpu,
  input  ppu_pkg::scan_pos_t pos,
  input  logic               is_pre_render,
  output logic [14:0]        loopy,
  output logic [2:0]         fine_x
);
  import ppu_pkg::*;

  logic [14:0] v;          // Current VRAM address
  logic [14:0] t;          // Temporary address
  logic [2:0]  x;
  logic        incr_32;    // Data access step, 1 or 32
  logic        wr_latch;   // Second write of scroll or address
  logic [8:0]  cycle;
  logic        coarse_x_step;

  assign cycle = pos.cycle;
  // Right after each attribute fetch, in the visible and prefetch ranges
  assign coarse_x_step = (cycle[2:0] == 3'd3) &&
                         ((cycle < COARSE_X_END) ||
                          (cycle >= PREFETCH_START && cycle < PREFETCH_END));

  always_ff @(posedge clk) begin
    if (reset) begin
      v        <= '0;
      t        <= '0;
      x        <= '0;
      incr_32  <= 1'b0;
      wr_latch <= 1'b0;
    end else if (ce) begin
      if (is_rendering) begin
        if (coarse_x_step) begin
          v[4:0] <= v[4:0] + 5'd1;
          v[10]  <= v[10] ^ (v[4:0] == 5'd31);  // Next horizontal name table
        end
        if (cycle == V_INCR_CYCLE) begin
          v[14:12] <= v[14:12] + 3'd1;
          if (v[14:12] == 3'd7) begin
            if (v[9:5] == COARSE_Y_WRAP) begin
              v[9:5] <= 5'd0;
              v[11]  <= !v[11];
            end else begin
              v[9:5] <= v[9:5] + 5'd1;
            end
          end
        end
        if (cycle == H_COPY_CYCLE) {v[10], v[4:0]} <= {t[10], t[4:0]};
        if (cycle == V_COPY_CYCLE && is_pre_render) v <= t;
      end
      if (cpu.write && cpu.ain == REG_CTRL) begin
        t[11:10] <= cpu.din[1:0];
        incr_32  <= cpu.din[2];
      end else if (cpu.write && cpu.ain == REG_SCROLL) begin
        if (!wr_latch) begin
          t[4:0] <= cpu.din[7:3];                 // Coarse X
          x      <= cpu.din[2:0];
        end else begin
          t[9:5]   <= cpu.din[7:3];               // Coarse Y
          t[14:12] <= cpu.din[2:0];               // Fine Y
        end
        wr_latch <= !wr_latch;
      end else if (cpu.write && cpu.ain == REG_ADDR) begin
        if (!wr_latch) begin
          t[13:8] <= cpu.din[5:0];
          t[14]   <= 1'b0;
        end else begin
          t[7:0] <= cpu.din;
          v      <= {t[14:8], cpu.din};
        end
        wr_latch <= !wr_latch;
      end else if (cpu.read && cpu.ain == REG_STATUS) begin
        wr_latch <= 1'b0;
      end else if ((cpu.read || cpu.write) && cpu.ain == REG_DATA && !is_rendering) begin
        v <= v + (incr_32 ? 15'd32 : 15'd1);
      end
    end
  end

  assign loopy  = v;
  assign fine_x = x;

endmodule

`default_nettype wire

// File: verilog/bg_painter.sv
// Background tile fetch registers and pixel shift pipes
// Loads a new tile every 8 cycles and picks the pixel by fine X
`default_nettype none

module bg_painter (
  input  logic        clk,
  input  logic        reset,
  input  logic        ce,
  input  logic        enable,
  input  logic [2:0]  cycle,
  input  logic [2:0]  fine_x,
  input  logic [14:0] loopy,
  input  logic [7:0]  vram_din,
  output logic [7:0]  name_table,
  output logic [3:0]  pixel
);

  logic [15:0] patt_lo_pipe;
  logic [15:0] patt_hi_pipe;
  logic [8:0]  attr_lo_pipe;
  logic [8:0]  attr_hi_pipe;
  logic [7:0]  nt_byte;        // Tile index
  logic [1:0]  attr_bits;      // Palette select of the quadrant
  logic [7:0]  patt_lo;        // Low plane, high plane arrives at phase 7
  logic [7:0]  attr_shifted;

  // Leftmost pixel sits in the MSB of a pattern byte
  function automatic logic [7:0] reverse8(input logic [7:0] b);
    logic [7:0] r;
    for (int i = 0; i < 8; i++) r[i] = b[7 - i];
    return r;
  endfunction

  // Quadrant from coarse X bit 1 and coarse Y bit 1
  assign attr_shifted = vram_din >> {loopy[6], loopy[1], 1'b0};

  always_ff @(posedge clk) begin
    if (reset) begin
      nt_byte      <= '0;
      attr_bits    <= '0;
      patt_lo      <= '0;
      patt_lo_pipe <= '0;
      patt_hi_pipe <= '0;
      attr_lo_pipe <= '0;
      attr_hi_pipe <= '0;
    end else if (ce) begin
      case (cycle)
        3'd1: nt_byte   <= vram_din;
        3'd3: attr_bits <= attr_shifted[1:0];
        3'd5: patt_lo   <= vram_din;
        default: ;
      endcase
      if (enable) begin
        patt_lo_pipe[14:0] <= patt_lo_pipe[15:1];
        patt_hi_pipe[14:0] <= patt_hi_pipe[15:1];
        attr_lo_pipe[7:0]  <= attr_lo_pipe[8:1];
        attr_hi_pipe[7:0]  <= attr_hi_pipe[8:1];
        if (cycle == 3'd7) begin              // Reload on the last pixel of a tile
          patt_lo_pipe[15:8] <= reverse8(patt_lo);
          patt_hi_pipe[15:8] <= reverse8(vram_din);
          attr_lo_pipe[8]    <= attr_bits[0];
          attr_hi_pipe[8]    <= attr_bits[1];
        end
      end
    end
  end

  assign name_table = nt_byte;
  assign pixel = {attr_hi_pipe[fine_x], attr_lo_pipe[fine_x],
                  patt_hi_pipe[fine_x], patt_lo_pipe[fine_x]};

endmodule

`default_nettype wire

// File: verilog/palette_ram.sv
// 32-entry background palette with mirrored backdrop entries
// Read is combinational, write is taken on the clock edge
`default_nettype none

module palette_ram (
  input  logic       clk,
  input  logic       ce,
  input  logic [4:0] addr,
  input  logic [5:0] din,
  input  logic       write,
  input  logic       grayscale,
  output logic [5:0] color
);

  logic [5:0] mem [0:31];
  logic [4:0] eff_addr;
  logic [5:0] raw;

  // Every x0, x4, x8, xC slot reads the shared backdrop
  assign eff_addr = (addr[1:0] == 2'b00) ? 5'd0 : addr;
  assign raw      = mem[eff_addr];

  always_ff @(posedge clk) begin
    // Mirrored x4/x8/xC writes are dropped
    if (ce && write && !(addr[3:2] != 2'b00 && addr[1:0] == 2'b00))
      mem[eff_addr] <= din;
  end

  assign color = grayscale ? {raw[5:4], 4'b0000} : raw;  // Keep luma only

endmodule

`default_nettype wire

// File: verilog/ppu_control.sv
// Control and mask registers, vblank NMI, VRAM request generation
// Also builds the CPU read data and the left-column clipped palette index
`default_nettype none

module ppu_control (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  ce,
  input  ppu_pkg::cpu_bus_t     cpu,
  input  ppu_pkg::scan_pos_t    pos,
  input  ppu_pkg::scan_events_t events,
  input  logic [14:0]           loopy,
  input  logic [7:0]            name_table,
  input  logic [3:0]            bg_pixel_raw,
  input  logic [5:0]            color,
  input  logic [7:0]            vram_din,
  output logic                  is_rendering,
  output ppu_pkg::ppu_ctrl_t    ctrl,
  output ppu_pkg::vram_req_t    vram,
  output logic [4:0]            pal_addr,
  output logic                  pal_write,
  output logic [7:0]            dout,
  output logic                  nmi
);
  import ppu_pkg::*;

  ppu_ctrl_t   ctrl_q;          // Bits kept from registers 0 and 1
  logic        nmi_occurred;    // Vblank flag, bit 7 of status
  logic [7:0]  vram_latch;      // Read buffer for the data register
  logic [8:0]  cycle;
  logic        cpu_data_rd;
  logic        cpu_data_wr;
  logic        status_rd;
  logic        is_pal_address;
  logic        show_bg;
  logic [3:0]  bg_pixel;

  assign cycle          = pos.cycle;
  assign cpu_data_rd    = cpu.read && (cpu.ain == REG_DATA);
  assign cpu_data_wr    = cpu.write && (cpu.ain == REG_DATA);
  assign status_rd      = cpu.read && (cpu.ain == REG_STATUS);
  assign is_pal_address = (loopy[13:8] == PALETTE_PAGE);
  assign ctrl           = ctrl_q;

  // Visible only with playfield on, off the pre-render gap and the idle line
  assign is_rendering = ctrl_q.enable_playfield && !events.in_vblank &&
                        (pos.scanline != VBLANK_START_LINE);

  // Left 8 columns drop to backdrop unless clip is disabled
  assign show_bg  = ctrl_q.playfield_clip || (cycle[7:3] != 5'd0);
  assign bg_pixel = {bg_pixel_raw[3:2], show_bg ? bg_pixel_raw[1:0] : 2'b00};

  always_ff @(posedge clk) begin
    if (reset) begin
      ctrl_q <= '0;
    end else if (ce && cpu.write) begin
      case (cpu.ain)
        REG_CTRL: begin
          ctrl_q.bg_patt    <= cpu.din[4];
          ctrl_q.vbl_enable <= cpu.din[7];
        end
        REG_MASK: begin
          ctrl_q.grayscale        <= cpu.din[0];
          ctrl_q.playfield_clip   <= cpu.din[1];
          ctrl_q.enable_playfield <= cpu.din[3];
        end
        default: ;
      endcase
    end
  end

  // Later assignments win, a status read clears even on the set cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      nmi_occurred <= 1'b0;
    end else if (ce) begin
      if (events.exiting_vblank) nmi_occurred <= 1'b0;
      if (events.entering_vblank) nmi_occurred <= 1'b1;
      if (status_rd) nmi_occurred <= 1'b0;
    end
  end

  assign nmi = nmi_occurred && ctrl_q.vbl_enable;

  // Data register reads return the previous fetch
  always_ff @(posedge clk) begin
    if (ce && cpu_data_rd) vram_latch <= vram_din;
  end

  always_comb begin
    vram.wdata = cpu.din;
    if (!is_rendering)
      vram.addr = loopy[13:0];                                            // CPU access
    else if (cycle[2:1] == 2'd0)
      vram.addr = {2'b10, loopy[11:0]};                                   // Name table
    else if (cycle[2:1] == 2'd1)
      vram.addr = {2'b10, loopy[11:10], 4'b1111, loopy[9:7], loopy[4:2]}; // Attribute
    else
      vram.addr = {1'b0, ctrl_q.bg_patt, name_table, cycle[1], loopy[14:12]};
    // Fetch on even cycles, except the closing cycle of a line
    vram.rd = cpu_data_rd || (is_rendering && !cycle[0] && !events.end_of_line);
    vram.wr = cpu_data_wr && !is_pal_address && !is_rendering;
  end

  assign pal_write = cpu_data_wr && is_pal_address;
  assign pal_addr  = is_rendering ? {1'b0, bg_pixel} :
                     is_pal_address ? loopy[4:0] : 5'd0;

  always_comb begin
    if (cpu.ain == REG_STATUS)
      dout = {nmi_occurred, 7'b0000000};  // Sprite flags read as zero
    else if (is_pal_address)
      dout = {2'b00, color};
    else
      dout = vram_latch;
  end

endmodule

`default_nettype wire

// File: verilog/ppu_top.sv
// Background PPU top level
// Ties the control block to the timer, scroll, painter and palette datapath
`default_nettype none

module ppu_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 ce,
  input  ppu_pkg::cpu_bus_t    cpu,
  input  logic [7:0]           vram_din,
  output logic [7:0]           dout,
  output logic                 nmi,
  output ppu_pkg::vram_req_t   vram,
  output logic [5:0]           color,
  output ppu_pkg::scan_pos_t   pos
);
  import ppu_pkg::*;

  scan_events_t events;
  ppu_ctrl_t    ctrl;
  logic         is_rendering;
  logic [14:0]  loopy;            // Current VRAM address v
  logic [2:0]   fine_x;
  logic [7:0]   name_table;       // Tile index for the pattern fetch
  logic [3:0]   bg_pixel_raw;     // Attribute and pattern bits before clipping
  logic [4:0]   pal_addr;
  logic         pal_write;

  ppu_control u_control (
    .clk(clk), .reset(reset), .ce(ce),
    .cpu(cpu), .pos(pos), .events(events),
    .loopy(loopy), .name_table(name_table), .bg_pixel_raw(bg_pixel_raw),
    .color(color), .vram_din(vram_din),
    .is_rendering(is_rendering), .ctrl(ctrl), .vram(vram),
    .pal_addr(pal_addr), .pal_write(pal_write),
    .dout(dout), .nmi(nmi)
  );

  scan_timer u_timer (
    .clk(clk), .reset(reset), .ce(ce),
    .is_rendering(is_rendering), .pos(pos), .events(events)
  );

  loopy_scroll u_scroll (
    .clk(clk), .reset(reset), .ce(ce),
    .is_rendering(is_rendering), .cpu(cpu), .pos(pos),
    .is_pre_render(events.is_pre_render),
    .loopy(loopy), .fine_x(fine_x)
  );

  // Pipes hold still during the last cycle group of a line
  bg_painter u_painter (
    .clk(clk), .reset(reset), .ce(ce),
    .enable(!events.at_last_cycle_group), .cycle(pos.cycle[2:0]),
    .fine_x(fine_x), .loopy(loopy), .vram_din(vram_din),
    .name_table(name_table), .pixel(bg_pixel_raw)
  );

  palette_ram u_palette (
    .clk(clk), .ce(ce),
    .addr(pal_addr), .din(cpu.din[5:0]), .write(pal_write),
    .grayscale(ctrl.grayscale), .color(color)
  );

endmodule

`default_nettype wire

// File: verification/ppu_tb.sv
// Directed testbench for the background PPU top level
// Drives the CPU bus, models VRAM and checks timing, NMI, VRAM access, palette and painting
`default_nettype none

module ppu_tb;
  import ppu_pkg::*;

  localparam int DRIVE_DELAY  = 10;          // Inputs change this long after the rising edge
  localparam int FRAME_CYCLES = 341 * 262;
  localparam int WAIT_LIMIT   = 100000;      // A bit more than one frame

  logic        clk;
  logic        reset;
  logic        ce;
  cpu_bus_t    cpu;
  logic [7:0]  vram_din;
  logic [7:0]  dout;
  logic        nmi;
  vram_req_t   vram;
  logic [5:0]  color;
  scan_pos_t   pos;

  logic [7:0]  vram_mem [0:16383];    // VRAM model
  logic [5:0]  pal_exp [0:31];        // Colors as written, per slot
  logic [5:0]  backdrop_exp;
  logic [31:0] rnd_state;
  logic [7:0]  dout_s;                // Outputs seen in the strobe cycle
  vram_req_t   vram_s;
  int          errors;
  int          checks;

  ppu_top uut (
    .clk(clk), .reset(reset), .ce(ce), .cpu(cpu), .vram_din(vram_din),
    .dout(dout), .nmi(nmi), .vram(vram), .color(color), .pos(pos)
  );

  assign vram_din = vram_mem[vram.addr];  // Combinational VRAM

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Slots x0, x4, x8 and xC all show the backdrop
  function automatic logic [5:0] expected_color(input logic [4:0] idx);
    return (idx[1:0] == 2'b00) ? backdrop_exp : pal_exp[idx];
  endfunction

  // Patterns all ones, name and attribute tables zero, upper space from the address
  function automatic logic [7:0] fill_value(input logic [13:0] a);
    case (a[13:12])
      2'b00, 2'b01: return 8'hFF;
      2'b10:        return 8'h00;
      default:      return a[7:0] ^ {2'b00, a[13:8]};
    endcase
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    checks++;
    assert (got === want) else begin
      $display("Mismatch %s: got %h, expected %h", name, got, want);
      errors++;
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("Error: %s", what);
      errors++;
    end
  endtask

  task automatic fill_vram();
    logic [13:0] a;
    for (int i = 0; i < 16384; i++) begin
      a = 14'(i);
      vram_mem[a] = fill_value(a);
    end
  endtask

  // One bus cycle, starting and ending at the drive point
  task automatic cpu_access(input logic [2:0] ain, input logic [7:0] din,
                            input logic rd, input logic wr);
    cpu.ain   = ain;
    cpu.din   = din;
    cpu.read  = rd;
    cpu.write = wr;
    @(negedge clk);
    dout_s = dout;
    vram_s = vram;
    if (vram.wr) vram_mem[vram.addr] = vram.wdata;  // Model records the write
    @(posedge clk);
    #DRIVE_DELAY;
    cpu.read  = 1'b0;
    cpu.write = 1'b0;
  endtask

  task automatic cpu_write(input logic [2:0] ain, input logic [7:0] din);
    cpu_access(ain, din, 1'b0, 1'b1);
  endtask

  task automatic cpu_read(input logic [2:0] ain);
    cpu_access(ain, 8'h00, 1'b1, 1'b0);
  endtask

  // Status read clears the write latch so the high byte goes first
  task automatic set_vram_addr(input logic [13:0] addr);
    cpu_read(REG_STATUS);
    cpu_write(REG_ADDR, {2'b00, addr[13:8]});
    cpu_write(REG_ADDR, addr[7:0]);
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk);
    #DRIVE_DELAY;
  endtask

  // Returns on the falling edge where pos matches
  task automatic wait_pos(input logic [8:0] line, input logic [8:0] cyc);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!(pos.scanline == line && pos.cycle == cyc) && n < WAIT_LIMIT);
    expect_true(pos.scanline == line && pos.cycle == cyc,
                "timed out waiting for a scan position");
  endtask

  task automatic frame_timing();
    scan_pos_t  prev;
    logic [8:0] next_line;
    int         count;
    wait_pos(9'd0, 9'd0);
    count = 0;
    do begin
      prev = pos;
      @(negedge clk);
      count++;
      if (prev.cycle == 9'd340) begin                  // Line wrap
        next_line = (prev.scanline == 9'd260) ? 9'h1FF : prev.scanline + 9'd1;
        compare_value("pos.cycle", 32'(pos.cycle), 32'd0);
        compare_value("pos.scanline", 32'(pos.scanline), 32'(next_line));
      end else begin
        compare_value("pos.cycle", 32'(pos.cycle), 32'(prev.cycle + 9'd1));
        compare_value("pos.scanline", 32'(pos.scanline), 32'(prev.scanline));
      end
    end while (!(pos.scanline == 9'd0 && pos.cycle == 9'd0) && count < WAIT_LIMIT);
    compare_value("frame length", 32'(count), 32'(FRAME_CYCLES));
    idle(1);
  endtask

  task automatic vblank_nmi();
    int n;
    cpu_read(REG_STATUS);                // Drop any old vblank flag
    cpu_write(REG_CTRL, 8'h80);
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!nmi && n < WAIT_LIMIT);
    expect_true(nmi, "nmi never rose after line 240");
    compare_value("pos.scanline", 32'(pos.scanline), 32'd241);
    compare_value("pos.cycle", 32'(pos.cycle), 32'd0);
    idle(1);
    cpu_read(REG_STATUS);
    compare_value("dout", 32'(dout_s), 32'h80);
    @(negedge clk);
    compare_value("nmi", 32'(nmi), 32'd0);   // Cleared by the status read
    idle(1);
    cpu_read(REG_STATUS);
    compare_value("dout", 32'(dout_s), 32'h00);
  endtask

  task automatic vram_write_steps();
    logic [7:0]  data;
    logic [13:0] addr;
    cpu_write(REG_CTRL, 8'h00);
    for (int pass = 0; pass < 2; pass++) begin
      if (pass == 1) cpu_write(REG_CTRL, 8'h04);   // Step 32
      set_vram_addr(14'h2100);
      for (int i = 0; i < 3; i++) begin
        data = {4'hA, 2'(pass), 2'(i)};
        addr = 14'h2100 + ((pass == 1) ? 14'(32 * i) : 14'(i));
        cpu_write(REG_DATA, data);
        compare_value("vram.wr", 32'(vram_s.wr), 32'd1);
        compare_value("vram.addr", 32'(vram_s.addr), 32'(addr));
        compare_value("vram.wdata", 32'(vram_s.wdata), 32'(data));
      end
    end
    compare_value("vram model 0x2140", 32'(vram_mem[14'h2140]), 32'hA6);
  endtask

  task automatic buffered_read();
    cpu_write(REG_CTRL, 8'h00);
    vram_mem[14'h3200] = 8'h96;
    vram_mem[14'h3123] = 8'h5A;
    set_vram_addr(14'h3200);
    cpu_read(REG_DATA);                   // Loads the read buffer
    compare_value("vram.rd", 32'(vram_s.rd), 32'd1);
    compare_value("vram.addr", 32'(vram_s.addr), 32'h3200);
    idle(2);
    set_vram_addr(14'h3123);
    cpu_read(REG_DATA);
    compare_value("dout", 32'(dout_s), 32'h96);    // Stale byte
    idle(2);
    cpu_read(REG_DATA);
    compare_value("dout", 32'(dout_s), 32'h5A);
  endtask

  task automatic palette_readback(input logic gray);
    logic [5:0] want;
    set_vram_addr(14'h3F00);
    for (int i = 0; i < 32; i++) begin
      want = expected_color(5'(i));
      if (gray) want = {want[5:4], 4'h0};       // Luma only
      cpu_read(REG_DATA);
      compare_value("dout", 32'(dout_s), 32'(want));
    end
  endtask

  task automatic palette_colors();
    logic [4:0] idx;
    logic [5:0] val;
    rnd_state = 32'd18827;
    set_vram_addr(14'h3F00);
    for (int i = 0; i < 32; i++) begin
      idx = 5'(i);
      rnd_state = next_random(rnd_state);
      val = rnd_state[5:0];
      cpu_write(REG_DATA, {2'b00, val});
      compare_value("vram.wr", 32'(vram_s.wr), 32'd0);  // Palette stays off the VRAM bus
      if (idx[1:0] != 2'b00) pal_exp[idx] = val;
      else if (idx[3:2] == 2'b00) backdrop_exp = val;  // 0x00 and 0x10 share it
    end
    palette_readback(1'b0);
    cpu_write(REG_MASK, 8'h01);
    palette_readback(1'b1);
    cpu_write(REG_MASK, 8'h00);
  endtask

  task automatic background_paint();
    logic [5:0] want;
    int         n;
    fill_vram();
    cpu_write(REG_MASK, 8'h08);           // Playfield on, left column clipped
    wait_pos(9'd10, 9'd0);
    for (n = 0; n < 251; n++) begin
      if (pos.cycle < 9'd8) want = expected_color(5'd0);
      else want = expected_color(5'd3);   // Pattern ones, attribute zero
      if (pos.cycle < 9'd8 || pos.cycle >= 9'd16)
        compare_value("color", 32'(color), 32'(want));
      @(negedge clk);
    end
    idle(1);
    cpu_write(REG_MASK, 8'h00);
  endtask

  initial begin
    errors       = 0;
    checks       = 0;
    reset        = 1'b1;
    ce           = 1'b1;
    cpu          = '0;
    backdrop_exp = '0;
    rnd_state    = 32'd18827;
    fill_vram();
    repeat (10) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    frame_timing();
    vblank_nmi();
    vram_write_steps();
    buffered_read();
    palette_colors();
    background_paint();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
verilog/ppu_pkg.sv
verilog/scan_timer.sv
verilog/loopy_scroll.sv
verilog/bg_painter.sv
verilog/palette_ram.sv
verilog/ppu_control.sv
verilog/ppu_top.sv
verification/ppu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ppu_tb \
  -f sources.f --Mdir obj_dir -o ppu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/ppu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1
